// ==== logic/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Set associativity
`define CACHE_WAYS 2

// Lanes per way, as an index width
`define CACHE_LANES_W 2

// Words per line, as an offset width
`define CACHE_OFFSET_W 2

// Addresses with this bit clear go straight to memory
`define CACHE_CACHED_BIT 31

`endif

// ==== logic/cache_cmd_pkg.sv ====
package cache_cmd_pkg;

    // Commands from the core, anything else is illegal
    typedef enum logic [2:0] {
        CMD_NONE      = 3'd0,
        CMD_LOAD      = 3'd1,
        CMD_STORE     = 3'd2,
        CMD_FLUSH_ALL = 3'd3
    } cache_cmd_t;

    // Exactly one non-idle response per command
    typedef enum logic [2:0] {
        RESP_IDLE        = 3'd0,
        RESP_DONE        = 3'd1,
        RESP_UNKNOWNTYPE = 3'd2,
        RESP_MISALIGNED  = 3'd3,
        RESP_ACCESSFAULT = 3'd4
    } cache_resp_t;

    // Same codes as the RISC-V funct3 field
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd4,
        LHU = 3'd5
    } load_type_t;

    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2
    } store_type_t;

endpackage

// ==== logic/cache_addr_pkg.sv ====
`include "cache_cfg.svh"

package cache_addr_pkg;

    localparam int LANES_W  = `CACHE_LANES_W;
    localparam int OFFSET_W = `CACHE_OFFSET_W;
    localparam int INWORD_W = 2;
    localparam int TAG_W    = 32 - LANES_W - OFFSET_W - INWORD_W;
    localparam int WAY_W    = (`CACHE_WAYS > 1) ? $clog2(`CACHE_WAYS) : 1;

    typedef logic [TAG_W-1:0]    ctag_t;
    typedef logic [WAY_W-1:0]    way_idx_t;
    typedef logic [LANES_W-1:0]  lane_idx_t;
    typedef logic [OFFSET_W-1:0] word_off_t;

    // Storage view
    typedef struct packed {
        ctag_t               tag;
        lane_idx_t           lane;
        word_off_t           offset;
        logic [INWORD_W-1:0] inword;
    } cache_fields_t;

    // Memory port view, word address and byte in word
    typedef struct packed {
        logic [31-INWORD_W:0] word_addr;
        logic [INWORD_W-1:0]  inword;
    } mem_fields_t;

    typedef union packed {
        cache_fields_t cache;
        mem_fields_t   mem;
    } cache_addr_u;

endpackage

// ==== logic/cache_ways.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_ways
    import cache_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_accept,
    input  cache_addr_u req_address,
    input  logic        fill_write,
    input  way_idx_t    fill_way,
    input  word_off_t   fill_offset,
    input  logic [31:0] fill_data,
    input  logic        fill_done,
    input  logic        store_update,
    input  logic [31:0] store_word,
    input  logic [3:0]  store_strb,
    input  logic        flush,
    output logic        hit,
    output way_idx_t    hit_way,
    output logic [31:0] hit_data,
    output way_idx_t    victim_way,
    output cache_addr_u line_addr
);

    localparam int LANES   = 1 << LANES_W;
    localparam int ENTRIES = 1 << (LANES_W + OFFSET_W);

    ctag_t            tag_mem  [`CACHE_WAYS][LANES];
    logic [7:0]       data_mem [`CACHE_WAYS][4][ENTRIES];
    logic [LANES-1:0] valid    [`CACHE_WAYS];

    cache_addr_u addr_q;
    ctag_t       rd_tag  [`CACHE_WAYS];
    logic [31:0] rd_data [`CACHE_WAYS];
    way_idx_t    victim_q;

    logic [LANES_W+OFFSET_W-1:0] rd_index;
    logic [LANES_W+OFFSET_W-1:0] wr_index;
    logic                        wr_en;
    logic [3:0]                  wr_strb;
    logic [31:0]                 wr_data;

    assign rd_index = {req_address.cache.lane, req_address.cache.offset};

    // One write port, shared by refill words and store merges
    assign wr_en    = fill_write || store_update;
    assign wr_index = store_update ? {addr_q.cache.lane, addr_q.cache.offset}
                                   : {addr_q.cache.lane, fill_offset};
    assign wr_strb  = store_update ? store_strb : 4'hF;
    assign wr_data  = store_update ? store_word : fill_data;

    always_ff @(posedge clk) begin
        if (req_accept) begin
            addr_q <= req_address;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                rd_tag[w] <= tag_mem[w][req_address.cache.lane];
                for (int b = 0; b < 4; b++) begin
                    rd_data[w][8*b +: 8] <= data_mem[w][b][rd_index];
                end
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (wr_en && wr_strb[b]) begin
                data_mem[fill_way][b][wr_index] <= wr_data[8*b +: 8];
            end
        end
        if (fill_done) begin
            tag_mem[fill_way][addr_q.cache.lane] <= addr_q.cache.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid[w] <= '0;
            end
            victim_q <= '0;
        end else if (fill_done) begin
            valid[fill_way][addr_q.cache.lane] <= 1'b1;
            if (victim_q == way_idx_t'(`CACHE_WAYS - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end else if (fill_write) begin
            // Lane holds a mix of old and new words until the refill ends
            valid[fill_way][addr_q.cache.lane] <= 1'b0;
        end
    end

    // Tag compare against the held address
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_data = rd_data[0];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (addr_q[`CACHE_CACHED_BIT] && valid[w][addr_q.cache.lane]
                    && rd_tag[w] == addr_q.cache.tag) begin
                hit      = 1'b1;
                hit_way  = way_idx_t'(w);
                hit_data = rd_data[w];
            end
        end
    end

    assign victim_way = victim_q;
    assign line_addr  = addr_q;

endmodule

// ==== logic/access_format.sv ====
`timescale 1ns/1ps

module access_format
    import cache_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        req_accept,
    input  load_type_t  c_load_type,
    input  store_type_t c_store_type,
    input  logic [31:0] c_store_data,
    input  cache_cmd_t  c_cmd,
    input  logic [1:0]  inword,
    input  logic [31:0] word_in,
    output cache_cmd_t  cmd_q,
    output logic [31:0] load_data,
    output logic [31:0] store_word,
    output logic [3:0]  store_strb,
    output logic        misaligned,
    output logic        unknown_type
);

    load_type_t  load_type_q;
    store_type_t store_type_q;
    logic [31:0] store_data_q;
    logic [31:0] shifted;
    logic        load_bad;
    logic        load_misaligned;
    logic        store_bad;
    logic        store_misaligned;

    always_ff @(posedge clk) begin
        if (req_accept) begin
            cmd_q        <= c_cmd;
            load_type_q  <= c_load_type;
            store_type_q <= c_store_type;
            store_data_q <= c_store_data;
        end
    end

    // Addressed byte or half moved down to bit 0
    assign shifted = word_in >> {inword, 3'b000};

    always_comb begin
        load_bad        = 1'b0;
        load_misaligned = 1'b0;
        case (load_type_q)
            LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            LBU: load_data = {24'h0, shifted[7:0]};
            LH: begin
                load_data       = {{16{shifted[15]}}, shifted[15:0]};
                load_misaligned = inword[0];
            end
            LHU: begin
                load_data       = {16'h0, shifted[15:0]};
                load_misaligned = inword[0];
            end
            LW: begin
                load_data       = word_in;
                load_misaligned = |inword;
            end
            default: begin
                load_data = word_in;
                load_bad  = 1'b1;
            end
        endcase
    end

    // Store data is replicated, strobes pick the lanes
    always_comb begin
        store_bad        = 1'b0;
        store_misaligned = 1'b0;
        case (store_type_q)
            SB: begin
                store_word = {4{store_data_q[7:0]}};
                store_strb = 4'b0001 << inword;
            end
            SH: begin
                store_word       = {2{store_data_q[15:0]}};
                store_strb       = 4'b0011 << inword;
                store_misaligned = inword[0];
            end
            SW: begin
                store_word       = store_data_q;
                store_strb       = 4'b1111;
                store_misaligned = |inword;
            end
            default: begin
                store_word = store_data_q;
                store_strb = 4'b0000;
                store_bad  = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (cmd_q)
            CMD_LOAD: begin
                misaligned   = load_misaligned;
                unknown_type = load_bad;
            end
            CMD_STORE: begin
                misaligned   = store_misaligned;
                unknown_type = store_bad;
            end
            CMD_FLUSH_ALL: begin
                misaligned   = 1'b0;
                unknown_type = 1'b0;
            end
            default: begin
                misaligned   = 1'b0;
                unknown_type = 1'b1;
            end
        endcase
    end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_ctrl
    import cache_cmd_pkg::*, cache_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cache_cmd_t  c_cmd,
    output cache_resp_t c_response,
    output logic [31:0] c_load_data,
    output logic        req_accept,
    input  cache_cmd_t  cmd_q,
    input  logic        hit,
    input  way_idx_t    hit_way,
    input  logic [31:0] hit_data,
    input  way_idx_t    victim_way,
    input  cache_addr_u line_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] store_word,
    input  logic [3:0]  store_strb,
    input  logic        misaligned,
    input  logic        unknown_type,
    output logic [31:0] word_in,
    output logic        fill_write,
    output way_idx_t    fill_way,
    output word_off_t   fill_offset,
    output logic        fill_done,
    output logic        store_update,
    output logic        flush,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wstrb,
    input  logic        mem_resp,
    input  logic [31:0] mem_rdata,
    input  logic        mem_err
);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_CHECK  = 3'd1;
    localparam logic [2:0] ST_REFILL = 3'd2;
    localparam logic [2:0] ST_BYPASS = 3'd3;
    localparam logic [2:0] ST_STORE  = 3'd4;

    logic [2:0]  state;
    logic [2:0]  state_nxt;
    word_off_t   fill_cnt;
    word_off_t   next_off;
    logic [31:0] word_q;
    logic        is_load;
    logic        cacheable;
    logic        last_word;
    logic        want_word;
    logic        issue_fill;
    logic        issue_single;
    cache_addr_u fill_addr;

    assign is_load   = (cmd_q == CMD_LOAD);
    assign cacheable = line_addr[`CACHE_CACHED_BIT];
    assign last_word = (fill_cnt == '1);
    assign want_word = (fill_cnt == line_addr.cache.offset);

    always_comb begin
        state_nxt    = state;
        c_response   = RESP_IDLE;
        req_accept   = 1'b0;
        flush        = 1'b0;
        issue_fill   = 1'b0;
        issue_single = 1'b0;
        case (state)
            ST_IDLE: begin
                if (c_cmd != CMD_NONE) begin
                    req_accept = 1'b1;
                    state_nxt  = ST_CHECK;
                end
            end
            ST_CHECK: begin
                state_nxt = ST_IDLE;
                if (cmd_q == CMD_FLUSH_ALL) begin
                    flush      = 1'b1;
                    c_response = RESP_DONE;
                end else if (unknown_type) begin
                    c_response = RESP_UNKNOWNTYPE;
                end else if (misaligned) begin
                    c_response = RESP_MISALIGNED;
                end else if (is_load && hit) begin
                    c_response = RESP_DONE;
                end else if (is_load && cacheable) begin
                    state_nxt  = ST_REFILL;
                    issue_fill = 1'b1;
                end else begin
                    // Bypassed load or write-through store, one transfer
                    state_nxt    = is_load ? ST_BYPASS : ST_STORE;
                    issue_single = 1'b1;
                end
            end
            ST_REFILL: begin
                if (mem_resp) begin
                    if (mem_err) begin
                        c_response = RESP_ACCESSFAULT;
                        state_nxt  = ST_IDLE;
                    end else if (last_word) begin
                        c_response = RESP_DONE;
                        state_nxt  = ST_IDLE;
                    end else begin
                        issue_fill = 1'b1;
                    end
                end
            end
            ST_BYPASS, ST_STORE: begin
                if (mem_resp) begin
                    c_response = mem_err ? RESP_ACCESSFAULT : RESP_DONE;
                    state_nxt  = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign fill_write   = (state == ST_REFILL) && mem_resp && !mem_err;
    assign fill_done    = fill_write && last_word;
    assign fill_offset  = fill_cnt;
    // Stores land in the way that hit, refills in the victim
    assign fill_way     = (state == ST_STORE) ? hit_way : victim_way;
    assign store_update = (state == ST_STORE) && mem_resp && !mem_err && hit;

    // Word handed to the load formatter
    always_comb begin
        case (state)
            ST_REFILL: word_in = want_word ? mem_rdata : word_q;
            ST_BYPASS: word_in = mem_rdata;
            default:   word_in = hit_data;
        endcase
    end

    assign c_load_data = load_data;

    // Refill walks the line from word 0
    assign next_off = (state == ST_CHECK) ? '0 : fill_cnt + 1'b1;

    always_comb begin
        fill_addr              = line_addr;
        fill_addr.cache.offset = next_off;
        fill_addr.cache.inword = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
        end else begin
            state   <= state_nxt;
            mem_req <= issue_fill || issue_single;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fill) begin
            mem_addr <= fill_addr;
            mem_we   <= 1'b0;
            fill_cnt <= next_off;
        end
        if (issue_single) begin
            mem_addr  <= {line_addr.mem.word_addr, 2'b00};
            mem_we    <= (cmd_q == CMD_STORE);
            mem_wdata <= store_word;
            mem_wstrb <= store_strb;
        end
        // Requested word kept for the final response
        if (fill_write && want_word) begin
            word_q <= mem_rdata;
        end
    end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top
    import cache_cmd_pkg::*, cache_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cache_cmd_t  c_cmd,
    input  logic [31:0] c_address,
    input  load_type_t  c_load_type,
    input  store_type_t c_store_type,
    input  logic [31:0] c_store_data,
    output cache_resp_t c_response,
    output logic [31:0] c_load_data,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wstrb,
    input  logic        mem_resp,
    input  logic [31:0] mem_rdata,
    input  logic        mem_err
);

    logic        req_accept;
    cache_cmd_t  cmd_q;
    logic        hit;
    way_idx_t    hit_way;
    logic [31:0] hit_data;
    way_idx_t    victim_way;
    cache_addr_u line_addr;
    logic [31:0] word_in;
    logic [31:0] load_data;
    logic [31:0] store_word;
    logic [3:0]  store_strb;
    logic        misaligned;
    logic        unknown_type;
    logic        fill_write;
    way_idx_t    fill_way;
    word_off_t   fill_offset;
    logic        fill_done;
    logic        store_update;
    logic        flush;

    // Refill words come straight from the memory port
    cache_ways u_ways (
        .*,
        .req_address (c_address),
        .fill_data   (mem_rdata)
    );

    access_format u_format (
        .*,
        .inword (line_addr.cache.inword)
    );

    cache_ctrl u_ctrl (
        .*
    );

endmodule

// ==== tb/cache_assert.sv ====
`timescale 1ns/1ps

module cache_assert
    import cache_cmd_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input cache_resp_t c_response,
    input logic        mem_req,
    input logic        mem_resp,
    input logic        mem_we,
    input logic [3:0]  mem_wstrb
);

    // Quiet ports right after reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (c_response == RESP_IDLE && !mem_req))
        else $error("cache not idle after reset");

    req_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> !mem_req)
        else $error("mem_req held for more than one cycle");

    write_strobes: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && mem_we) |-> (mem_wstrb != 4'h0))
        else $error("memory write without byte strobes");

    no_req_on_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (c_response != RESP_IDLE) |-> !mem_req)
        else $error("memory request in the response cycle");

endmodule

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
    import cache_cmd_pkg::*;
();

    localparam int RESP_TIMEOUT = 200;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    cache_cmd_t  c_cmd = CMD_NONE;
    logic [31:0] c_address = '0;
    load_type_t  c_load_type = LW;
    store_type_t c_store_type = SW;
    logic [31:0] c_store_data = '0;
    cache_resp_t c_response;
    logic [31:0] c_load_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_resp = 1'b0;
    logic [31:0] mem_rdata = '0;
    logic        mem_err = 1'b0;

    // Memory model state, only words that were written are stored
    logic [31:0] mem_words [logic [29:0]];
    logic        pend = 1'b0;
    int          delay_left = 0;
    logic [31:0] pend_addr;
    logic        pend_we;
    logic [31:0] pend_wdata;
    logic [3:0]  pend_wstrb;
    int          req_total = 0;

    cache_top uut (.*);

    bind cache_top cache_assert u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_response (c_response),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .mem_we     (mem_we),
        .mem_wstrb  (mem_wstrb)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_resp(input cache_resp_t got, input cache_resp_t exp, input int lineno);
        if (got !== exp) begin
            abort_run($sformatf("FAIL c_response: got %h expected %h (data line %0d)",
                                got, exp, lineno));
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input int lineno);
        if (got !== exp) begin
            abort_run($sformatf("FAIL c_load_data: got %h expected %h (data line %0d)",
                                got, exp, lineno));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp,
                               input int lineno);
        if (got != exp) begin
            abort_run($sformatf("FAIL %s: got %0h expected %0h (data line %0d)",
                                name, got, exp, lineno));
        end
    endtask

    // Untouched words read back as the word address xor a fixed pattern
    function automatic logic [31:0] model_word(input logic [29:0] w);
        if (mem_words.exists(w)) begin
            return mem_words[w];
        end
        return {2'b00, w} ^ 32'h5A5A0000;
    endfunction

    function automatic logic in_error_page(input logic [31:0] a);
        return a[31:12] == 20'h7F000;
    endfunction

    always @(posedge clk) begin : memory_model
        logic [29:0] w;
        logic [31:0] merged;
        mem_resp <= 1'b0;
        if (mem_req) begin
            if (pend) begin
                abort_run("cache issued a memory request while another was outstanding");
            end
            req_total  <= req_total + 1;
            pend       <= 1'b1;
            pend_addr  <= mem_addr;
            pend_we    <= mem_we;
            pend_wdata <= mem_wdata;
            pend_wstrb <= mem_wstrb;
            delay_left <= 1 + int'($urandom % 4);
        end else if (pend) begin
            if (delay_left > 1) begin
                delay_left <= delay_left - 1;
            end else begin
                w = pend_addr[31:2];
                pend     <= 1'b0;
                mem_resp <= 1'b1;
                if (in_error_page(pend_addr)) begin
                    mem_err   <= 1'b1;
                    mem_rdata <= '0;
                end else begin
                    merged = model_word(w);
                    if (pend_we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (pend_wstrb[b]) begin
                                merged[8*b +: 8] = pend_wdata[8*b +: 8];
                            end
                        end
                        mem_words[w] = merged;
                    end
                    mem_err   <= 1'b0;
                    mem_rdata <= merged;
                end
            end
        end
    end

    task automatic run_request(
        input cache_cmd_t  cmd,
        input logic [31:0] addr,
        input logic [2:0]  typ,
        input logic [31:0] sdata,
        input cache_resp_t exp_resp,
        input logic [31:0] exp_data,
        input int          exp_count,
        input int          lineno
    );
        int start_count;
        int waited;
        @(posedge clk);
        c_cmd        <= cmd;
        c_address    <= addr;
        c_load_type  <= load_type_t'(typ);
        c_store_type <= store_type_t'(typ[1:0]);
        c_store_data <= sdata;
        start_count  = req_total;
        @(posedge clk);
        c_cmd <= CMD_NONE;
        waited = 1;
        @(negedge clk);
        while (c_response == RESP_IDLE) begin
            if (waited >= RESP_TIMEOUT) begin
                abort_run($sformatf("no response to the request on data line %0d", lineno));
            end
            @(negedge clk);
            waited++;
        end
        check_resp(c_response, exp_resp, lineno);
        if (cmd == CMD_LOAD && exp_resp == RESP_DONE) begin
            check_data(c_load_data, exp_data, lineno);
        end
        check_count("mem_req count", req_total - start_count, exp_count, lineno);
        // Anything answered without memory must come back in one cycle
        if (exp_count == 0) begin
            check_count("response latency", waited, 1, lineno);
        end
    endtask

    initial begin : stimulus
        int          fd;
        int          records;
        int          lineno;
        int          fields;
        string       line;
        logic [31:0] f_cmd;
        logic [31:0] f_addr;
        logic [31:0] f_typ;
        logic [31:0] f_sdata;
        logic [31:0] f_resp;
        logic [31:0] f_data;
        logic [31:0] f_count;
        void'($urandom(97170));
        fd = $fopen("tb/cache_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/cache_testdata.txt");
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        records = 0;
        lineno  = 0;
        while ($fgets(line, fd) != 0) begin
            lineno++;
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h", f_cmd, f_addr, f_typ,
                                 f_sdata, f_resp, f_data, f_count);
                if (fields != 7) begin
                    abort_run($sformatf("data line %0d does not hold seven fields", lineno));
                end
                run_request(cache_cmd_t'(f_cmd[2:0]), f_addr, f_typ[2:0], f_sdata,
                            cache_resp_t'(f_resp[2:0]), f_data, int'(f_count), lineno);
                records++;
            end
        end
        $fclose(fd);
        if (records > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("test data file holds no requests");
        end
    end

endmodule

// ==== tb/cache_testdata.txt ====
# cmd addr type store_data exp_resp exp_load_data exp_mem_requests, all hex
# cmd 1 load 2 store 3 flush, resp 1 done 2 unknown 3 misaligned 4 accessfault
1 80001004 2 00000000 1 7A5A0401 4
1 80001008 2 00000000 1 7A5A0402 0
1 83C272D0 2 00000000 1 7AAA9CB4 4
1 83C272D1 0 00000000 1 FFFFFF9C 0
1 83C272D2 4 00000000 1 000000AA 0
1 83C272D7 0 00000000 1 0000007A 0
1 83C272D0 1 00000000 1 FFFF9CB4 0
1 83C272D2 5 00000000 1 00007AAA 0
1 83C272D4 0 00000000 1 FFFFFFB5 0
2 80001005 0 000000EE 1 00000000 1
1 80001004 2 00000000 1 7A5AEE01 0
2 8000100A 1 0000BEEF 1 00000000 1
1 8000100A 5 00000000 1 0000BEEF 0
1 80001002 2 00000000 3 00000000 0
2 80001001 1 00001234 3 00000000 0
1 80001000 3 00000000 2 00000000 0
5 80001000 0 00000000 2 00000000 0
3 00000000 0 00000000 1 00000000 0
1 80001004 2 00000000 1 7A5AEE01 4
1 80001008 2 00000000 1 BEEF0402 0
1 00002008 2 00000000 1 5A5A0802 1
1 00002008 2 00000000 1 5A5A0802 1
2 00002008 2 CAFEF00D 1 00000000 1
1 00002009 0 00000000 1 FFFFFFF0 1
1 7F000010 2 00000000 4 00000000 1
2 7F000020 2 11111111 4 00000000 1
2 80002000 2 DEADBEEF 1 00000000 1
1 80002000 2 00000000 1 DEADBEEF 4

// ==== src.f ====
+incdir+logic
logic/cache_cmd_pkg.sv
logic/cache_addr_pkg.sv
logic/cache_ways.sv
logic/access_format.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/cache_assert.sv
tb/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f src.f -o cache_sim

./obj_dir/cache_sim
